/* rtl/sa_array.sv */
/*
  4x4 grid. Activations move right along a row, sums move down a column.
  Row r must arrive r cycles after row 0 for the sums to line up.
*/
module sa_array
  import sa_pkg::*;
(
  input  logic     ap_clk,
  input  logic     areset,
  input  logic     weight_wr,
  input  row_idx_t weight_row,
  input  beat_t    weight_data,
  input  pe_link_t row_in  [ARRAY_DIM],
  output pe_link_t col_out [ARRAY_DIM]
);

  // act[r][c] feeds element (r,c), sum[r][c] enters element (r,c) from above
  pe_link_t act [ARRAY_DIM][ARRAY_DIM];
  pe_link_t sum [ARRAY_DIM+1][ARRAY_DIM];

  for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_edge
    assign sum[0][c]  = '0;
    assign col_out[c] = sum[ARRAY_DIM][c];
  end

  for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
    assign act[r][0] = row_in[r];

    for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
      logic  load;
      word_t w_word;

      // Weight row k goes to array row k, word c to column c
      assign load   = weight_wr && (weight_row == row_idx_t'(r));
      assign w_word = weight_data[(ARRAY_DIM-1-c)*WORD_W +: WORD_W];

      if (c < ARRAY_DIM - 1) begin : g_inner
        sa_pe i_pe (
          .ap_clk      (ap_clk),
          .areset      (areset),
          .weight_load (load),
          .weight_in   (w_word),
          .act_in      (act[r][c]),
          .sum_in      (sum[r][c]),
          .act_out     (act[r][c+1]),
          .sum_out     (sum[r+1][c])
        );
      end else begin : g_last
        // Rightmost column, activation ends here
        sa_pe i_pe (
          .ap_clk      (ap_clk),
          .areset      (areset),
          .weight_load (load),
          .weight_in   (w_word),
          .act_in      (act[r][c]),
          .sum_in      (sum[r][c]),
          .act_out     (),
          .sum_out     (sum[r+1][c])
        );
      end
    end
  end

endmodule

/* rtl/sa_ctrl.sv */
/*
  Job control. A start edge is honoured only in IDLE, row_count is taken there.
  A job with row_count 0 loads its weights and finishes without streaming.
*/
module sa_ctrl
  import sa_pkg::*;
(
  input  logic       ap_clk,
  input  logic       areset,
  input  logic       ap_start,
  input  row_count_t row_count,
  input  logic       weight_en,
  input  logic       in_en,
  input  logic       out_en,
  output logic       ap_idle,
  output logic       ap_done,
  output logic       weight_rdy,
  output logic       in_rdy,
  output logic       weight_wr,
  output row_idx_t   weight_row
);

  ctrl_state_t state;
  logic        start_q;
  logic        start_edge;
  logic        done_q;
  logic        in_take;
  logic        last_weight;
  logic        last_in;
  logic        last_out;
  row_idx_t    w_cnt;
  row_count_t  rows_q;
  row_count_t  in_cnt;
  row_count_t  out_cnt;

  assign start_edge = ap_start && !start_q;

  // Readies follow the phase directly
  assign weight_rdy = (state == LOAD);
  assign in_rdy     = (state == STREAM);

  assign weight_wr  = weight_en && weight_rdy;
  assign weight_row = w_cnt;
  assign in_take    = in_en && in_rdy;

  assign last_weight = weight_wr && (w_cnt == row_idx_t'(ARRAY_DIM - 1));
  assign last_in     = in_take && (in_cnt == rows_q - row_count_t'(1));
  assign last_out    = out_en && (out_cnt == rows_q - row_count_t'(1));

  assign ap_idle = (state == IDLE);
  assign ap_done = done_q;

  //////////////////////////////////////////////////
  // Phase FSM and counters
  //////////////////////////////////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state   <= IDLE;
      start_q <= 1'b0;
      done_q  <= 1'b0;
      w_cnt   <= '0;
      in_cnt  <= '0;
      out_cnt <= '0;
    end else begin
      start_q <= ap_start;
      done_q  <= 1'b0;
      case (state)
        IDLE: begin
          if (start_edge) begin
            state   <= LOAD;
            w_cnt   <= '0;
            in_cnt  <= '0;
            out_cnt <= '0;
          end
        end
        LOAD: begin
          if (weight_wr) begin
            w_cnt <= w_cnt + row_idx_t'(1);
          end
          // All weights loaded, compute phase begins
          if (last_weight) begin
            if (rows_q == '0) begin
              state  <= IDLE;
              done_q <= 1'b1;
            end else begin
              state <= STREAM;
            end
          end
        end
        STREAM: begin
          if (in_take) begin
            in_cnt <= in_cnt + row_count_t'(1);
          end
          if (last_in) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          // Done only once the final result has left the array
          if (last_out) begin
            state  <= IDLE;
            done_q <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
      if (out_en) begin
        out_cnt <= out_cnt + row_count_t'(1);
      end
    end
  end

  // Job length, captured with the start edge
  always_ff @(posedge ap_clk) begin
    if (state == IDLE && start_edge) begin
      rows_q <= row_count;
    end
  end

endmodule

/* rtl/sa_pe.sv */
/*
  One element: stored weight, registered activation, registered partial sum.
  The product uses the registered activation, so each element costs one cycle.
*/
module sa_pe
  import sa_pkg::*;
(
  input  logic     ap_clk,
  input  logic     areset,
  input  logic     weight_load,
  input  word_t    weight_in,
  input  pe_link_t act_in,
  input  pe_link_t sum_in,
  output pe_link_t act_out,
  output pe_link_t sum_out
);

  word_t weight_q;
  word_t partial;

  // An invalid incoming sum counts as zero
  assign partial = sum_in.valid ? sum_in.value : '0;

  always_ff @(posedge ap_clk) begin
    if (weight_load) begin
      weight_q <= weight_in;
    end
  end

  //////////////////////////////////////////////////
  // Forwarding and MAC registers
  //////////////////////////////////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      act_out.valid <= 1'b0;
      sum_out.valid <= 1'b0;
    end else begin
      act_out.valid <= act_in.valid;
      sum_out.valid <= act_out.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    act_out.value <= act_in.value;
    // Wraps modulo 2^32
    sum_out.value <= partial + act_out.value * weight_q;
  end

endmodule

/* rtl/sa_pkg.sv */
/*
  Shared sizes and types for the 4x4 systolic matrix unit.
  Lane 0 of a beat sits in its most significant word.
*/
package sa_pkg;

  //////////////////////////////////////////////////
  // Array geometry
  //////////////////////////////////////////////////
  localparam int ARRAY_DIM    = 4;
  localparam int WORD_W       = 32;
  localparam int BEAT_W       = ARRAY_DIM * WORD_W;

  // Accepted input beat to its out_en, in cycles
  localparam int PIPE_LATENCY = 2 * ARRAY_DIM;

  localparam int ROW_COUNT_W  = 16;
  localparam int ROW_IDX_W    = $clog2(ARRAY_DIM);

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////
  typedef logic [WORD_W-1:0]      word_t;
  typedef logic [BEAT_W-1:0]      beat_t;
  typedef logic [ROW_COUNT_W-1:0] row_count_t;
  typedef logic [ROW_IDX_W-1:0]   row_idx_t;

  // One hop between neighbouring elements
  typedef struct packed {
    logic  valid;
    word_t value;
  } pe_link_t;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    STREAM,
    DRAIN
  } ctrl_state_t;

endpackage

/* rtl/sa_skew.sv */
/*
  Per-lane delay lines. REVERSE 0 delays lane i by i cycles,
  REVERSE 1 by ARRAY_DIM-1-i. A zero-depth lane passes straight through.
*/
module sa_skew
  import sa_pkg::*;
#(
  parameter bit REVERSE = 1'b0
) (
  input  logic     ap_clk,
  input  logic     areset,
  input  pe_link_t lanes_in  [ARRAY_DIM],
  output pe_link_t lanes_out [ARRAY_DIM]
);

  for (genvar i = 0; i < ARRAY_DIM; i++) begin : g_lane
    localparam int DEPTH = REVERSE ? (ARRAY_DIM - 1 - i) : i;

    if (DEPTH == 0) begin : g_thru
      assign lanes_out[i] = lanes_in[i];
    end else begin : g_dly
      pe_link_t stage [DEPTH];

      // Valids only, so bubbles stay bubbles after reset
      always_ff @(posedge ap_clk) begin
        if (areset) begin
          for (int k = 0; k < DEPTH; k++) begin
            stage[k].valid <= 1'b0;
          end
        end else begin
          stage[0].valid <= lanes_in[i].valid;
          for (int k = 1; k < DEPTH; k++) begin
            stage[k].valid <= stage[k-1].valid;
          end
        end
      end

      always_ff @(posedge ap_clk) begin
        stage[0].value <= lanes_in[i].value;
        for (int k = 1; k < DEPTH; k++) begin
          stage[k].value <= stage[k-1].value;
        end
      end

      assign lanes_out[i] = stage[DEPTH-1];
    end
  end

endmodule

/* rtl/sa_top.sv */
/*
  Systolic matrix unit top. Results leave PIPE_LATENCY cycles after each
  accepted input beat and cannot be stalled.
*/
module sa_top
  import sa_pkg::*;
(
  input  logic       ap_clk,
  input  logic       areset,
  input  logic       ap_start,
  input  row_count_t row_count,
  input  logic       weight_en,
  input  beat_t      weight_data,
  input  logic       in_en,
  input  beat_t      in_data,
  output logic       ap_idle,
  output logic       ap_done,
  output logic       weight_rdy,
  output logic       in_rdy,
  output logic       out_en,
  output beat_t      out_data
);

  logic     in_take;
  logic     weight_wr;
  row_idx_t weight_row;
  pe_link_t in_lanes    [ARRAY_DIM];
  pe_link_t skewed      [ARRAY_DIM];
  pe_link_t col_sums    [ARRAY_DIM];
  pe_link_t out_lanes   [ARRAY_DIM];

  assign in_take = in_en && in_rdy;

  //////////////////////////////////////////////////
  // Beat unpack and pack
  //////////////////////////////////////////////////
  for (genvar i = 0; i < ARRAY_DIM; i++) begin : g_lane
    assign in_lanes[i].valid = in_take;
    assign in_lanes[i].value = in_data[(ARRAY_DIM-1-i)*WORD_W +: WORD_W];
    assign out_data[(ARRAY_DIM-1-i)*WORD_W +: WORD_W] = out_lanes[i].value;
  end

  // All columns are aligned after deskew
  assign out_en = out_lanes[0].valid;

  sa_ctrl i_ctrl (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .ap_start   (ap_start),
    .row_count  (row_count),
    .weight_en  (weight_en),
    .in_en      (in_en),
    .out_en     (out_en),
    .ap_idle    (ap_idle),
    .ap_done    (ap_done),
    .weight_rdy (weight_rdy),
    .in_rdy     (in_rdy),
    .weight_wr  (weight_wr),
    .weight_row (weight_row)
  );

  sa_skew #(
    .REVERSE (1'b0)
  ) i_skew_in (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .lanes_in  (in_lanes),
    .lanes_out (skewed)
  );

  sa_array i_array (
    .ap_clk      (ap_clk),
    .areset      (areset),
    .weight_wr   (weight_wr),
    .weight_row  (weight_row),
    .weight_data (weight_data),
    .row_in      (skewed),
    .col_out     (col_sums)
  );

  sa_skew #(
    .REVERSE (1'b1)
  ) i_deskew (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .lanes_in  (col_sums),
    .lanes_out (out_lanes)
  );

endmodule

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps --top-module tb_top \
    -f verilog.f -o tb_top_sim > build.log 2>&1; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_top_sim > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -qx "No errors" sim.log; then
  exit 0
fi
exit 1

/* tb/sa_checker.sv */
/*
  Samples the DUT ports on each rising edge and compares against expected rows
  handed over with every accepted input beat. Counts errors, never stops the run.
*/
module sa_checker
  import sa_pkg::*;
(
  input  logic       ap_clk,
  input  logic       areset,
  input  logic       ap_start,
  input  row_count_t row_count,
  input  logic       weight_en,
  input  logic       in_en,
  input  beat_t      exp_data,
  input  logic       ap_idle,
  input  logic       ap_done,
  input  logic       weight_rdy,
  input  logic       in_rdy,
  input  logic       out_en,
  input  beat_t      out_data,
  output int         value_errs,
  output int         proto_errs,
  output int         pending_rows
);
  timeunit 1ns;
  timeprecision 1ps;

  beat_t exp_q  [$];
  int    sent_q [$];
  int    cycle;
  int    job_rows;
  int    w_taken;
  int    out_seen;
  logic  start_q;
  logic  started;
  logic  job_active;
  logic  edge_q;
  logic  idle_q;
  logic  last_out_q;

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("** Error %s: got %h expected %h", name, got, want);
      proto_errs++;
    end
  endtask

  task automatic protocol_fail(input string what);
    $display("Protocol failure in cycle %0d, %s", cycle, what);
    proto_errs++;
  endtask

  //////////////////////////////////////////////////
  // Per-cycle checks
  //////////////////////////////////////////////////
  always @(posedge ap_clk) begin
    beat_t want;
    int    sent_at;
    logic  new_job;
    if (areset) begin
      exp_q.delete();
      sent_q.delete();
      {start_q, started, job_active, edge_q, idle_q, last_out_q} = '0;
      {cycle, job_rows, w_taken, out_seen, value_errs, proto_errs} = '0;
    end else begin
      cycle++;
      new_job = ap_start && !start_q && ap_idle;
      // Quiet ports until the first job
      if (!started) begin
        check_bit("ap_idle", ap_idle, 1'b1);
        check_bit("ap_done", ap_done, 1'b0);
        check_bit("weight_rdy", weight_rdy, 1'b0);
        check_bit("in_rdy", in_rdy, 1'b0);
        check_bit("out_en", out_en, 1'b0);
      end
      if (edge_q) begin
        check_bit("ap_idle", ap_idle, 1'b0);
        check_bit("weight_rdy", weight_rdy, 1'b1);
      end
      if (weight_rdy && w_taken >= ARRAY_DIM) begin
        protocol_fail("weight_rdy still high after four weight beats");
      end
      if (in_rdy && w_taken != ARRAY_DIM) begin
        protocol_fail($sformatf("in_rdy high after %0d weight beats", w_taken));
      end
      if (weight_en && weight_rdy) begin
        w_taken++;
      end
      if (in_en && in_rdy) begin
        exp_q.push_back(exp_data);
        sent_q.push_back(cycle);
      end
      if (out_en) begin
        if (exp_q.size() == 0) begin
          protocol_fail("out_en with no input row in flight");
        end else begin
          want    = exp_q.pop_front();
          sent_at = sent_q.pop_front();
          if (out_data !== want) begin
            $display("** Error out_data: got %h expected %h", out_data, want);
            value_errs++;
          end
          if (cycle - sent_at != PIPE_LATENCY) begin
            protocol_fail($sformatf("result came %0d cycles after its input",
                                    cycle - sent_at));
          end
        end
        out_seen++;
      end
      if (ap_done) begin
        if (!job_active) begin
          protocol_fail("ap_done with no job running");
        end
        if (!last_out_q) begin
          protocol_fail("ap_done not in the cycle after the last out_en");
        end
        if (out_seen != job_rows) begin
          $display("** Error out_en count: got %h expected %h", out_seen, job_rows);
          value_errs++;
        end
        check_bit("ap_idle", ap_idle, 1'b1);
        if (idle_q) begin
          protocol_fail("ap_idle already high before ap_done");
        end
        job_active = 1'b0;
      end else if (last_out_q) begin
        protocol_fail("ap_done missing after the last out_en");
      end
      last_out_q = job_active && out_en && (out_seen == job_rows);
      edge_q     = new_job;
      if (new_job) begin
        job_rows   = int'(row_count);
        w_taken    = 0;
        out_seen   = 0;
        job_active = 1'b1;
        started    = 1'b1;
      end
      start_q = ap_start;
      idle_q  = ap_idle;
    end
    pending_rows = exp_q.size();
  end

endmodule

/* tb/sa_stim.txt */
// Each job is a row count, four weight rows, then input and expected output rows in pairs
// A row is four 32-bit words with lane 0 first, and a row count of 0 ends the file
3
00000001000000020000000300000004
00000005000000060000000700000008
000000090000000a0000000b0000000c
0000000d0000000e0000000f00000010
00000001000000000000000000000000
00000001000000020000000300000004
00000001000000010000000100000001
0000001c000000200000002400000028
00000002000000000000000100000003
00000032000000380000003e00000044
// Single row with products that wrap
1
ffffffff000000010000000080000000
00000001ffffffff0000000000000000
00000000000000000000000200000000
00000000000000000000000000000001
00000002000000038000000000000010
00000001ffffffff0000000000000010
// New weights, several rows in flight
4
00010000000000000000000000000000
00000000000000030000000000000000
0000000000000000fffffffe00000000
00000001000000010000000100000001
00012345555555560000000300000001
2345000100000003fffffffb00000001
ffffffffffffffffffffffffffffffff
fffefffffffffffc00000001ffffffff
0000abcd000000108000000000000000
abcd0000000000300000000000000000
7fffffff2aaaaaab4000000100000002
ffff0002800000038000000000000002
0

/* tb/tb_top.sv */
/*
  Testbench for sa_top. Run from the project root so that tb/sa_stim.txt is found.
  Input beats are spaced by 0 to 3 idle cycles drawn from a seeded LCG.
*/
module tb_top
  import sa_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 10;
  localparam int STIM_DEPTH   = 64;

  logic       ap_clk = 1'b0;
  logic       areset = 1'b1;
  logic       ap_start;
  row_count_t row_count;
  logic       weight_en;
  beat_t      weight_data;
  logic       in_en;
  beat_t      in_data;
  beat_t      exp_data;
  logic       ap_idle;
  logic       ap_done;
  logic       weight_rdy;
  logic       in_rdy;
  logic       out_en;
  beat_t      out_data;

  int          value_errs;
  int          proto_errs;
  int          pending_rows;
  int          run_errs;
  int          limit_cycles;
  int unsigned lcg_state;
  beat_t       stim_mem [STIM_DEPTH];
  int          job_base [$];

  always #5 ap_clk = ~ap_clk;

  sa_top i_dut (.*);

  // Checker sees the same ports plus the expected row of each input beat
  sa_checker i_check (.*);

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////
  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  task automatic next_cycle();
    @(posedge ap_clk);
    #1;
  endtask

  task automatic send_weight(input beat_t row);
    logic taken;
    taken       = 1'b0;
    weight_en   = 1'b1;
    weight_data = row;
    while (!taken) begin
      @(posedge ap_clk);
      taken = weight_rdy;
      #1;
    end
    weight_en = 1'b0;
  endtask

  task automatic send_input(input beat_t row, input beat_t expected);
    logic taken;
    taken    = 1'b0;
    in_en    = 1'b1;
    in_data  = row;
    exp_data = expected;
    while (!taken) begin
      @(posedge ap_clk);
      taken = in_rdy;
      #1;
    end
    in_en = 1'b0;
  endtask

  task automatic run_job(input int base);
    int   rows;
    logic done_seen;
    rows      = int'(stim_mem[base][15:0]);
    done_seen = 1'b0;
    row_count = row_count_t'(rows);
    ap_start  = 1'b1;
    for (int k = 0; k < ARRAY_DIM; k++) begin
      send_weight(stim_mem[base + 1 + k]);
    end
    for (int n = 0; n < rows; n++) begin
      repeat (int'(next_random() % 32'd4)) next_cycle();
      send_input(stim_mem[base + 5 + 2 * n], stim_mem[base + 6 + 2 * n]);
      if (n == 0) begin
        // Second start edge mid-job, with a bogus row count
        ap_start  = 1'b0;
        row_count = '1;
        next_cycle();
        ap_start = 1'b1;
        next_cycle();
      end
    end
    while (!done_seen) begin
      @(posedge ap_clk);
      done_seen = ap_done;
      #1;
    end
    ap_start = 1'b0;
    next_cycle();
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin : main
    int   idx;
    int   rows;
    logic parsed;
    ap_start     = 1'b0;
    row_count    = '0;
    weight_en    = 1'b0;
    weight_data  = '0;
    in_en        = 1'b0;
    in_data      = '0;
    exp_data     = '0;
    lcg_state    = 32'd95;
    run_errs     = 0;
    limit_cycles = 0;
    idx          = 0;
    parsed       = 1'b0;
    $readmemh("tb/sa_stim.txt", stim_mem);

    // Walk the jobs once, which also sizes the watchdog
    while (!parsed) begin
      if (idx >= STIM_DEPTH) begin
        $display("Stimulus file has no closing row count of zero");
        run_errs++;
        parsed = 1'b1;
      end else if (stim_mem[idx] == '0) begin
        parsed = 1'b1;
      end else begin
        rows = int'(stim_mem[idx][15:0]);
        job_base.push_back(idx);
        limit_cycles += rows * 4 + PIPE_LATENCY + 20;
        idx += 5 + 2 * rows;
      end
    end
    if (job_base.size() == 0) begin
      $display("Stimulus file holds no job");
      run_errs++;
    end

    repeat (RESET_CYCLES) @(posedge ap_clk);
    #1;
    areset = 1'b0;
    repeat (3) next_cycle();
    foreach (job_base[j]) begin
      run_job(job_base[j]);
    end
    repeat (4) next_cycle();

    if (pending_rows != 0) begin
      $display("%0d input rows never produced a result", pending_rows);
      run_errs++;
    end
    $display("Error counts: %0d value, %0d protocol, %0d run",
             value_errs, proto_errs, run_errs);
    if (value_errs + proto_errs + run_errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    wait (!areset && limit_cycles > 0);
    repeat (limit_cycles) @(posedge ap_clk);
    $display("Timeout, jobs still running after %0d cycles", limit_cycles);
    $display("Errors found");
    $finish;
  end

endmodule

/* verilog.f */
rtl/sa_pkg.sv
rtl/sa_pe.sv
rtl/sa_skew.sv
rtl/sa_array.sv
rtl/sa_ctrl.sv
rtl/sa_top.sv
tb/sa_checker.sv
tb/tb_top.sv
